/* src/ex_consts.svh */
/*
 * Width constants for the execute stage: scalar data, PC,
 * lane slice width and number of lane slices.
 */
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// scalar operand and result width.
`define EX_DATA_WIDTH 32

// program counter width.
`define EX_ADDR_WIDTH 32

// one ALU slice.
`define EX_LANE_WIDTH 8

// data width over lane width, shared by the lane loop and the testbench.
`define EX_LANE_COUNT 4

`endif

/* src/ex_pkg.sv */
/*
 * Execute stage types: ALU op, SIMD element mode, branch condition
 * and the SIMD word union used to slice and rebuild operands.
 */
`include "ex_consts.svh"

package ex_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // 2'b11 is not a legal mode.
    typedef enum logic [1:0] {
        SIMD_W32 = 2'd0, // one 32-bit element.
        SIMD_H16 = 2'd1, // two 16-bit elements.
        SIMD_B8  = 2'd2  // four 8-bit elements.
    } simd_mode_e;

    typedef enum logic [2:0] {
        BR_BEQ  = 3'd0,
        BR_BNE  = 3'd1,
        BR_BLT  = 3'd2,
        BR_BGE  = 3'd3,
        BR_BLTU = 3'd4,
        BR_BGEU = 3'd5
    } br_type_e;

    typedef union packed {
        logic [`EX_DATA_WIDTH-1:0]                        word;
        logic [1:0][`EX_DATA_WIDTH/2-1:0]                 halves;
        logic [`EX_LANE_COUNT-1:0][`EX_LANE_WIDTH-1:0]    bytes;
    } simd_word_u;

endpackage

/* src/ex_operand_sel.sv */
/*
 * ALU operand selection, operand 2 conditioning for subtract,
 * and per-lane carry seeds and element boundary marks.
 */
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_operand_sel (
    input  logic                                          clk,
    input  logic                                          reset_i,
    input  logic                                          valid_i,
    input  logic                                          sel1_i,
    input  logic                                          sel2_i,
    input  logic [`EX_ADDR_WIDTH-1:0]                     now_pc_i,
    input  logic [`EX_DATA_WIDTH-1:0]                     rs1_data_i,
    input  logic [`EX_DATA_WIDTH-1:0]                     rs2_data_i,
    input  logic [`EX_DATA_WIDTH-1:0]                     imm_i,
    input  ex_pkg::alu_op_e                               alu_op_i,
    input  ex_pkg::simd_mode_e                            simd_mode_i,
    output logic [`EX_LANE_COUNT-1:0][`EX_LANE_WIDTH-1:0] lane_a_o,
    output logic [`EX_LANE_COUNT-1:0][`EX_LANE_WIDTH-1:0] lane_b_o,
    output logic [`EX_LANE_COUNT-1:0]                     lane_seed_o,
    output logic [`EX_LANE_COUNT-1:0]                     lane_first_o
);
    import ex_pkg::*;

    localparam int HALF_LANES = `EX_LANE_COUNT / 2;

    logic [`EX_DATA_WIDTH-1:0] op2_raw;
    simd_word_u                op1;
    simd_word_u                op2;
    logic                      is_sub;

    assign is_sub    = (alu_op_i == ALU_SUB);
    assign op1.word  = sel1_i ? now_pc_i : rs1_data_i;
    assign op2_raw   = sel2_i ? imm_i : rs2_data_i;
    assign op2.word  = is_sub ? ~op2_raw : op2_raw; // a - b as a + ~b + 1.

    assign lane_a_o    = op1.bytes;
    assign lane_b_o    = op2.bytes;
    assign lane_seed_o = {`EX_LANE_COUNT{is_sub}};

    // a lane is first when it starts an element.
    always_comb begin
        for (int k = 0; k < `EX_LANE_COUNT; k++) begin
            case (simd_mode_i)
                SIMD_B8:  lane_first_o[k] = 1'b1;
                SIMD_H16: lane_first_o[k] = ((k % HALF_LANES) == 0);
                default:  lane_first_o[k] = (k == 0);
            endcase
        end
    end

    a_mode_legal: assert property (@(posedge clk) disable iff (reset_i)
        valid_i |-> simd_mode_i inside {SIMD_W32, SIMD_H16, SIMD_B8})
        else $error("illegal SIMD mode with valid_i high");

endmodule

/* src/ex_lane.sv */
/*
 * One 8-bit ALU slice: add with carry in and carry out,
 * and the bitwise logic ops.
 */
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_lane (
    input  logic [`EX_LANE_WIDTH-1:0] a_i,
    input  logic [`EX_LANE_WIDTH-1:0] b_i,
    input  logic                      carry_i,
    input  ex_pkg::alu_op_e           alu_op_i,
    output logic [`EX_LANE_WIDTH-1:0] result_o,
    output logic                      carry_o
);
    import ex_pkg::*;

    logic [`EX_LANE_WIDTH:0] sum;

    // b_i is already inverted for subtract.
    assign sum = {1'b0, a_i} + {1'b0, b_i} + {{`EX_LANE_WIDTH{1'b0}}, carry_i};

    always_comb begin
        carry_o  = 1'b0;
        result_o = '0;
        case (alu_op_i)
            ALU_ADD,
            ALU_SUB: begin
                result_o = sum[`EX_LANE_WIDTH-1:0];
                carry_o  = sum[`EX_LANE_WIDTH]; // no-borrow flag on subtract.
            end
            ALU_AND: begin
                result_o = a_i & b_i;
            end
            ALU_OR: begin
                result_o = a_i | b_i;
            end
            ALU_XOR: begin
                result_o = a_i ^ b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

/* src/ex_result_merge.sv */
/*
 * Lane result gather, element carry masking and the EX/MEM
 * result register with its valid strobe.
 */
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_result_merge (
    input  logic                                          clk,
    input  logic                                          reset_i,
    input  logic                                          valid_i,
    input  ex_pkg::simd_mode_e                            simd_mode_i,
    input  logic [`EX_LANE_COUNT-1:0][`EX_LANE_WIDTH-1:0] lane_result_i,
    input  logic [`EX_LANE_COUNT-1:0]                     lane_carry_i,
    output logic [`EX_DATA_WIDTH-1:0]                     alu_data_o,
    output logic [`EX_LANE_COUNT-1:0]                     carry_o,
    output logic                                          valid_o
);
    import ex_pkg::*;

    localparam int HALF_LANES = `EX_LANE_COUNT / 2;

    simd_word_u                result_w;
    logic [`EX_LANE_COUNT-1:0] top_mask;
    logic [`EX_LANE_COUNT-1:0] first_q;
    simd_mode_e                mode_q;

    // marks the top lane of every element in a mode.
    function automatic logic [`EX_LANE_COUNT-1:0] elem_top(input simd_mode_e mode);
        logic [`EX_LANE_COUNT-1:0] mask;
        for (int k = 0; k < `EX_LANE_COUNT; k++) begin
            case (mode)
                SIMD_B8:  mask[k] = 1'b1;
                SIMD_H16: mask[k] = ((k % HALF_LANES) == HALF_LANES - 1);
                default:  mask[k] = (k == `EX_LANE_COUNT - 1);
            endcase
        end
        return mask;
    endfunction

    // marks the lane that starts every element in a mode.
    function automatic logic [`EX_LANE_COUNT-1:0] elem_first(input simd_mode_e mode);
        logic [`EX_LANE_COUNT-1:0] mask;
        for (int k = 0; k < `EX_LANE_COUNT; k++) begin
            case (mode)
                SIMD_B8:  mask[k] = 1'b1;
                SIMD_H16: mask[k] = ((k % HALF_LANES) == 0);
                default:  mask[k] = (k == 0);
            endcase
        end
        return mask;
    endfunction

    assign result_w.bytes = lane_result_i;
    assign top_mask       = elem_top(simd_mode_i);
    assign first_q        = elem_first(mode_q);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o    <= 1'b0;
            alu_data_o <= '0;
            carry_o    <= '0;
            mode_q     <= SIMD_W32;
        end else begin
            valid_o <= valid_i;
            if (valid_i) begin
                alu_data_o <= result_w.word;
                carry_o    <= lane_carry_i & top_mask;
                mode_q     <= simd_mode_i;
            end
        end
    end

    // a flag below the top lane needs a new element in the lane above it.
    a_carry_boundary: assert property (@(posedge clk) disable iff (reset_i)
        valid_o |-> ((carry_o[`EX_LANE_COUNT-2:0] & ~first_q[`EX_LANE_COUNT-1:1]) == '0))
        else $error("carry flag set inside an element");

endmodule

/* src/ex_branch.sv */
/*
 * Branch condition evaluation, misprediction flag and
 * next-PC computation, registered at the EX/MEM boundary.
 */
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_branch (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      valid_i,
    input  logic                      is_br_i,
    input  ex_pkg::br_type_e          br_type_i,
    input  logic                      bp_flag_i,
    input  logic [`EX_DATA_WIDTH-1:0] rs1_data_i,
    input  logic [`EX_DATA_WIDTH-1:0] rs2_data_i,
    input  logic [`EX_ADDR_WIDTH-1:0] now_pc_i,
    input  logic [`EX_DATA_WIDTH-1:0] imm_i,
    output logic                      branch_flag_o,
    output logic [`EX_ADDR_WIDTH-1:0] branch_pc_o
);
    import ex_pkg::*;

    logic                      eq;
    logic                      lt_s;
    logic                      lt_u;
    logic                      taken;
    logic [`EX_ADDR_WIDTH-1:0] next_pc;

    assign eq   = (rs1_data_i == rs2_data_i);
    assign lt_s = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign lt_u = (rs1_data_i < rs2_data_i);

    always_comb begin
        case (br_type_i)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            default: taken = 1'b0;
        endcase
    end

    // target when taken, fall-through otherwise.
    assign next_pc = taken ? (now_pc_i + imm_i) : (now_pc_i + `EX_ADDR_WIDTH'(4));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            branch_flag_o <= 1'b0;
            branch_pc_o   <= '0;
        end else begin
            branch_flag_o <= valid_i && is_br_i && (taken != bp_flag_i); // mispredicted.
            if (valid_i) begin
                branch_pc_o <= next_pc;
            end
        end
    end

    a_flag_needs_valid: assert property (@(posedge clk) disable iff (reset_i)
        !valid_i |=> !branch_flag_o)
        else $error("branch flag raised without a valid operation");

endmodule

/* src/ex_stage.sv */
/*
 * Execute stage top: operand selector, lane slices with the
 * element-cut carry chain, result merge and branch unit.
 */
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      valid_i,
    input  logic                      sel1_i,
    input  logic                      sel2_i,
    input  logic [`EX_ADDR_WIDTH-1:0] now_pc_i,
    input  logic [`EX_DATA_WIDTH-1:0] rs1_data_i,
    input  logic [`EX_DATA_WIDTH-1:0] rs2_data_i,
    input  logic [`EX_DATA_WIDTH-1:0] imm_i,
    input  ex_pkg::alu_op_e           alu_op_i,
    input  ex_pkg::simd_mode_e        simd_mode_i,
    input  logic                      is_br_i,
    input  ex_pkg::br_type_e          br_type_i,
    input  logic                      bp_flag_i,
    output logic [`EX_DATA_WIDTH-1:0] alu_data_o,
    output logic [`EX_LANE_COUNT-1:0] carry_o,
    output logic                      valid_o,
    output logic                      branch_flag_o,
    output logic [`EX_ADDR_WIDTH-1:0] branch_pc_o
);
    import ex_pkg::*;

    logic [`EX_LANE_COUNT-1:0][`EX_LANE_WIDTH-1:0] lane_a;
    logic [`EX_LANE_COUNT-1:0][`EX_LANE_WIDTH-1:0] lane_b;
    logic [`EX_LANE_COUNT-1:0][`EX_LANE_WIDTH-1:0] lane_result;
    logic [`EX_LANE_COUNT-1:0]                     lane_seed;
    logic [`EX_LANE_COUNT-1:0]                     lane_first;
    logic [`EX_LANE_COUNT-1:0]                     lane_cin;
    logic [`EX_LANE_COUNT-1:0]                     lane_cout;

    ex_operand_sel u_operand_sel (
        .clk          (clk),
        .reset_i      (reset_i),
        .valid_i      (valid_i),
        .sel1_i       (sel1_i),
        .sel2_i       (sel2_i),
        .now_pc_i     (now_pc_i),
        .rs1_data_i   (rs1_data_i),
        .rs2_data_i   (rs2_data_i),
        .imm_i        (imm_i),
        .alu_op_i     (alu_op_i),
        .simd_mode_i  (simd_mode_i),
        .lane_a_o     (lane_a),
        .lane_b_o     (lane_b),
        .lane_seed_o  (lane_seed),
        .lane_first_o (lane_first)
    );

    for (genvar k = 0; k < `EX_LANE_COUNT; k++) begin : g_lane
        // chain is cut where a new element starts.
        if (k == 0) begin : g_base
            assign lane_cin[k] = lane_seed[k];
        end else begin : g_chain
            assign lane_cin[k] = lane_first[k] ? lane_seed[k] : lane_cout[k-1];
        end

        ex_lane u_lane (
            .a_i      (lane_a[k]),
            .b_i      (lane_b[k]),
            .carry_i  (lane_cin[k]),
            .alu_op_i (alu_op_i),
            .result_o (lane_result[k]),
            .carry_o  (lane_cout[k])
        );
    end

    ex_result_merge u_result_merge (
        .clk           (clk),
        .reset_i       (reset_i),
        .valid_i       (valid_i),
        .simd_mode_i   (simd_mode_i),
        .lane_result_i (lane_result),
        .lane_carry_i  (lane_cout),
        .alu_data_o    (alu_data_o),
        .carry_o       (carry_o),
        .valid_o       (valid_o)
    );

    ex_branch u_branch (
        .clk           (clk),
        .reset_i       (reset_i),
        .valid_i       (valid_i),
        .is_br_i       (is_br_i),
        .br_type_i     (br_type_i),
        .bp_flag_i     (bp_flag_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .now_pc_i      (now_pc_i),
        .imm_i         (imm_i),
        .branch_flag_o (branch_flag_o),
        .branch_pc_o   (branch_pc_o)
    );

    a_logic_no_carry: assert property (@(posedge clk) disable iff (reset_i)
        (valid_i && (alu_op_i inside {ALU_AND, ALU_OR, ALU_XOR})) |-> (lane_cout == '0))
        else $error("lane carry out on a logic op");

endmodule

/* sim/ex_stage_tb.sv */
/*
 * Testbench for the execute stage: clock, reset, watchdog,
 * stimulus table with reference model, and output checks.
 */
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_stage_tb;
    import ex_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 16;
    localparam int TABLE_LEN    = 24;
    localparam int IDLE_AT      = 12; // cycle with valid_i low.
    localparam int RAND_SEED    = 65;
    localparam int WATCHDOG_NS  = (TABLE_LEN + RESET_CYCLES + 20) * CLK_PERIOD;

    typedef struct packed {
        alu_op_e                   op;
        simd_mode_e                mode;
        logic                      sel1;
        logic                      sel2;
        logic [`EX_ADDR_WIDTH-1:0] pc;
        logic [`EX_DATA_WIDTH-1:0] rs1;
        logic [`EX_DATA_WIDTH-1:0] rs2;
        logic [`EX_DATA_WIDTH-1:0] imm;
        logic                      is_br;
        br_type_e                  br;
        logic                      bp;
        logic [`EX_DATA_WIDTH-1:0] exp_data;
        logic [`EX_LANE_COUNT-1:0] exp_carry;
        logic                      exp_flag;
        logic [`EX_ADDR_WIDTH-1:0] exp_pc;
    } row_t;

    logic                      clk;
    logic                      reset_i;
    logic                      valid_i;
    logic                      sel1_i;
    logic                      sel2_i;
    logic [`EX_ADDR_WIDTH-1:0] now_pc_i;
    logic [`EX_DATA_WIDTH-1:0] rs1_data_i;
    logic [`EX_DATA_WIDTH-1:0] rs2_data_i;
    logic [`EX_DATA_WIDTH-1:0] imm_i;
    alu_op_e                   alu_op_i;
    simd_mode_e                simd_mode_i;
    logic                      is_br_i;
    br_type_e                  br_type_i;
    logic                      bp_flag_i;
    logic [`EX_DATA_WIDTH-1:0] alu_data_o;
    logic [`EX_LANE_COUNT-1:0] carry_o;
    logic                      valid_o;
    logic                      branch_flag_o;
    logic [`EX_ADDR_WIDTH-1:0] branch_pc_o;

    row_t rows [TABLE_LEN];
    int   n_rows;

    ex_stage uut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the stage did not finish the table within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    // element-wise arithmetic, flag at the top lane of each element.
    function automatic logic [`EX_DATA_WIDTH+`EX_LANE_COUNT-1:0] ref_alu(
        input alu_op_e op, input simd_mode_e mode,
        input logic [`EX_DATA_WIDTH-1:0] a, input logic [`EX_DATA_WIDTH-1:0] b);
        int                        ew;
        int                        top;
        logic [`EX_DATA_WIDTH:0]   mask;
        logic [`EX_DATA_WIDTH:0]   ea;
        logic [`EX_DATA_WIDTH:0]   eb;
        logic [`EX_DATA_WIDTH:0]   er;
        logic [`EX_DATA_WIDTH-1:0] res;
        logic [`EX_LANE_COUNT-1:0] cf;
        ew   = (mode == SIMD_B8) ? 8 : ((mode == SIMD_H16) ? 16 : 32);
        mask = ({{`EX_DATA_WIDTH{1'b0}}, 1'b1} << ew) - 1;
        res  = '0;
        cf   = '0;
        for (int e = 0; e < `EX_DATA_WIDTH / ew; e++) begin
            ea  = ({1'b0, a} >> (e * ew)) & mask;
            eb  = ({1'b0, b} >> (e * ew)) & mask;
            top = (e + 1) * ew / `EX_LANE_WIDTH - 1;
            er  = '0;
            case (op)
                ALU_ADD: begin
                    er      = ea + eb;
                    cf[top] = er[ew];
                end
                ALU_SUB: begin
                    er      = ea - eb;
                    cf[top] = (ea >= eb); // no borrow.
                end
                ALU_AND: er = ea & eb;
                ALU_OR:  er = ea | eb;
                ALU_XOR: er = ea ^ eb;
                default: er = '0;
            endcase
            res = res | `EX_DATA_WIDTH'((er & mask) << (e * ew));
        end
        return {res, cf};
    endfunction

    function automatic logic [`EX_ADDR_WIDTH:0] ref_branch(input br_type_e br,
        input logic is_br, input logic bp, input logic [`EX_DATA_WIDTH-1:0] rs1,
        input logic [`EX_DATA_WIDTH-1:0] rs2, input logic [`EX_ADDR_WIDTH-1:0] pc,
        input logic [`EX_DATA_WIDTH-1:0] imm);
        logic taken;
        case (br)
            BR_BEQ:  taken = (rs1 == rs2);
            BR_BNE:  taken = (rs1 != rs2);
            BR_BLT:  taken = ($signed(rs1) < $signed(rs2));
            BR_BGE:  taken = ($signed(rs1) >= $signed(rs2));
            BR_BLTU: taken = (rs1 < rs2);
            default: taken = (rs1 >= rs2);
        endcase
        return {is_br && (taken != bp), taken ? pc + imm : pc + 32'd4};
    endfunction

    task automatic add_row(input alu_op_e op, input simd_mode_e mode, input logic s1,
        input logic s2, input logic [31:0] pc, input logic [31:0] rs1, input logic [31:0] rs2,
        input logic [31:0] imm, input logic is_br, input br_type_e br, input logic bp);
        row_t r;
        r.op    = op;
        r.mode  = mode;
        r.sel1  = s1;
        r.sel2  = s2;
        r.pc    = pc;
        r.rs1   = rs1;
        r.rs2   = rs2;
        r.imm   = imm;
        r.is_br = is_br;
        r.br    = br;
        r.bp    = bp;
        {r.exp_data, r.exp_carry} = ref_alu(op, mode, s1 ? pc : rs1, s2 ? imm : rs2);
        {r.exp_flag, r.exp_pc}    = ref_branch(br, is_br, bp, rs1, rs2, pc, imm);
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic apply_row(input row_t r);
        valid_i     = 1'b1;
        alu_op_i    = r.op;
        simd_mode_i = r.mode;
        sel1_i      = r.sel1;
        sel2_i      = r.sel2;
        now_pc_i    = r.pc;
        rs1_data_i  = r.rs1;
        rs2_data_i  = r.rs2;
        imm_i       = r.imm;
        is_br_i     = r.is_br;
        br_type_i   = r.br;
        bp_flag_i   = r.bp;
    endtask

    task automatic check_value(input string field, input logic [31:0] got,
        input logic [31:0] exp);
        assert (got === exp) else begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, field, got, exp);
            $display("Test failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // data outputs hold the last issued row across an idle cycle.
    task automatic check_outputs(input bit was_idle, input int last);
        check_value("valid_o", 32'(valid_o), was_idle ? 32'd0 : 32'd1);
        check_value("branch_flag_o", 32'(branch_flag_o), was_idle ? 32'd0 : 32'(rows[last].exp_flag));
        check_value("alu_data_o", alu_data_o, rows[last].exp_data);
        check_value("carry_o", 32'(carry_o), 32'(rows[last].exp_carry));
        check_value("branch_pc_o", branch_pc_o, rows[last].exp_pc);
    endtask

    initial begin
        int  seed_state;
        int  last;
        int  next_row;
        bit  idle;
        bit  prev_idle;
        reset_i     = 1'b1;
        valid_i     = 1'b0;
        sel1_i      = 1'b0;
        sel2_i      = 1'b0;
        now_pc_i    = '0;
        rs1_data_i  = '0;
        rs2_data_i  = '0;
        imm_i       = '0;
        alu_op_i    = ALU_ADD;
        simd_mode_i = SIMD_W32;
        is_br_i     = 1'b0;
        br_type_i   = BR_BEQ;
        bp_flag_i   = 1'b0;
        seed_state  = $urandom(RAND_SEED);
        n_rows      = 0;

        add_row(ALU_ADD, SIMD_W32, 0, 0, 32'h1000, 32'hFFFFFFFF, 32'h1, 32'h10, 1, BR_BEQ, 0);
        add_row(ALU_SUB, SIMD_W32, 0, 0, 32'h1004, 32'h5, 32'h7, 32'hFFFFFFF8, 1, BR_BNE, 0);
        add_row(ALU_ADD, SIMD_W32, 1, 1, 32'h2000, 32'h3, 32'h9, 32'h24, 1, BR_BLT, 0);
        add_row(ALU_SUB, SIMD_W32, 0, 1, 32'h2008, 32'h100, 32'h100, 32'h10, 1, BR_BGE, 0);
        add_row(ALU_ADD, SIMD_H16, 0, 0, 32'h3000, 32'h00FF00FF, 32'h00010001, 32'h8, 1, BR_BLTU, 0);
        add_row(ALU_ADD, SIMD_B8, 0, 0, 32'h3004, 32'h00FF00FF, 32'h00010001, 32'h8, 1, BR_BGEU, 0);
        add_row(ALU_ADD, SIMD_H16, 0, 0, 32'h3008, 32'hFFFF0001, 32'h00010001, 32'h40, 1, BR_BEQ, 1);
        add_row(ALU_SUB, SIMD_B8, 0, 0, 32'h300C, 32'h10203040, 32'h01010101, 32'h40, 1, BR_BNE, 1);
        add_row(ALU_SUB, SIMD_H16, 0, 0, 32'h3010, 32'h00010005, 32'h00020003, 32'h40, 1, BR_BLT, 1);
        add_row(ALU_AND, SIMD_W32, 0, 0, 32'h3014, 32'hF0F0A5A5, 32'h0FF0FFFF, 32'h80, 1, BR_BGE, 1);
        add_row(ALU_OR, SIMD_H16, 1, 0, 32'h00FF1200, 32'h9, 32'h12340034, 32'h80, 1, BR_BLTU, 1);
        add_row(ALU_XOR, SIMD_B8, 0, 1, 32'h4000, 32'hA5A5A5A5, 32'h0, 32'h5A5A5A5A, 1, BR_BGEU, 1);
        add_row(ALU_XOR, SIMD_W32, 0, 0, 32'h4004, 32'h77, 32'h77, 32'h20, 0, BR_BEQ, 0);
        add_row(ALU_OR, SIMD_W32, 0, 0, 32'h4008, 32'h80000000, 32'h1, 32'h20, 1, BR_BLT, 0);
        add_row(ALU_AND, SIMD_B8, 0, 0, 32'h400C, 32'h80000000, 32'h1, 32'h20, 1, BR_BLTU, 1);
        add_row(ALU_ADD, SIMD_B8, 1, 1, 32'h0000FFFC, 32'hFFFFFFFF, 32'h0, 32'h4, 1, BR_BGE, 1);
        while (n_rows < TABLE_LEN) begin
            add_row(alu_op_e'($urandom % 5), simd_mode_e'($urandom % 3), 1'($urandom),
                1'($urandom), $urandom & 32'hFFFFFFFC, $urandom, $urandom, $urandom,
                1'($urandom), br_type_e'($urandom % 6), 1'($urandom));
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset_i = 1'b0;
        @(negedge clk);
        check_value("valid_o", 32'(valid_o), 32'd0);
        check_value("branch_flag_o", 32'(branch_flag_o), 32'd0);
        check_value("alu_data_o", alu_data_o, 32'd0);
        check_value("carry_o", 32'(carry_o), 32'd0);
        check_value("branch_pc_o", branch_pc_o, 32'd0);

        last      = -1;
        next_row  = 0;
        prev_idle = 1'b1;
        for (int c = 0; c <= TABLE_LEN + 1; c++) begin
            @(posedge clk);
            #1;
            idle = (c == IDLE_AT) || (c == TABLE_LEN + 1);
            if (idle) begin
                valid_i = 1'b0;
            end else begin
                apply_row(rows[next_row]);
            end
            @(negedge clk); // results of the previous cycle's row.
            if (c > 0) begin
                check_outputs(prev_idle, last);
            end
            prev_idle = idle;
            if (!idle) begin
                last = next_row;
                next_row++;
            end
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* ex_stage.f */
+incdir+src
src/ex_pkg.sv
src/ex_operand_sel.sv
src/ex_lane.sv
src/ex_result_merge.sv
src/ex_branch.sv
src/ex_stage.sv
sim/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

export_include_dirs:
  - src

sources:
  # execute stage RTL, package first
  - files:
      - src/ex_pkg.sv
      - src/ex_operand_sel.sv
      - src/ex_lane.sv
      - src/ex_result_merge.sv
      - src/ex_branch.sv
      - src/ex_stage.sv

  # testbench
  - target: test
    files:
      - sim/ex_stage_tb.sv
